// File: source/obi_stall_settings.svh
// Settings for the OBI stall memory: widths, depths, seed and APB register map
`ifndef OBI_STALL_SETTINGS_SVH
`define OBI_STALL_SETTINGS_SVH

// OBI data and address width
`define OBI_DATA_W 32

// RAM depth in words, indexed by address bits 9:2
`define OBI_MEM_WORDS 256

// Longest response delay, sets the delay line length
`define RSP_DELAY_MAX 7

// Grant LFSR start value, must not be zero
`define LFSR_SEED 16'hACE1

// APB register byte offsets
`define REG_CTRL      12'h000
`define REG_GNT_STALL 12'h004
`define REG_MAX_STALL 12'h008
`define REG_RSP_STALL 12'h00C

`endif

// File: source/obi_stall_pkg.sv
// Shared types for the OBI stall memory: stall mode, configuration and OBI bundles
`include "obi_stall_settings.svh"

package obi_stall_pkg;

  // --------------------------------------------------
  // Stall configuration
  // --------------------------------------------------

  // Grant stall mode, code 3 is not used
  typedef enum logic [1:0] {
    STALL_OFF    = 2'd0,
    STALL_FIXED  = 2'd1,
    STALL_RANDOM = 2'd2
  } stall_mode_e;

  // Whole configuration, 13 bits
  typedef struct packed {
    stall_mode_e mode;
    logic [3:0]  gnt_stall;   // Fixed grant delay
    logic [3:0]  max_stall;   // Upper bound in random mode
    logic [2:0]  rsp_stall;   // Response delay
  } stall_cfg_t;

  // --------------------------------------------------
  // OBI data port
  // --------------------------------------------------

  // Core to memory, held stable until granted
  typedef struct packed {
    logic                   req;
    logic                   we;
    logic [`OBI_DATA_W-1:0] addr;
    logic [`OBI_DATA_W-1:0] wdata;
  } obi_req_t;

  // Memory to core
  typedef struct packed {
    logic                   rvalid;
    logic [`OBI_DATA_W-1:0] rdata;
  } obi_rsp_t;

endpackage

// File: source/obi_stall_regs.sv
// APB register block holding the grant and response stall configuration
`timescale 1ns/1ps
`include "obi_stall_settings.svh"

module obi_stall_regs (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic [11:0]               paddr_i,
  input  logic                      psel_i,
  input  logic                      penable_i,
  input  logic                      pwrite_i,
  input  logic [31:0]               pwdata_i,
  output logic [31:0]               prdata_o,
  output logic                      pready_o,
  output logic                      pslverr_o,
  output obi_stall_pkg::stall_cfg_t cfg_o
);

  // --------------------------------------------------
  // Phase and address decode
  // --------------------------------------------------

  logic                       setup;
  logic                       access;
  logic                       addr_hit;
  logic [31:0]                rd_data;
  obi_stall_pkg::stall_mode_e wr_mode;
  obi_stall_pkg::stall_cfg_t  cfg_q;

  // Setup phase: selected, enable not yet up
  assign setup  = psel_i & ~penable_i;
  assign access = psel_i & penable_i;

  // Only the four registers are decoded
  assign addr_hit = (paddr_i == `REG_CTRL) || (paddr_i == `REG_GNT_STALL) ||
                    (paddr_i == `REG_MAX_STALL) || (paddr_i == `REG_RSP_STALL);

  // No wait states
  assign pready_o  = access;
  // Error only in the access phase of an unknown offset
  assign pslverr_o = access & ~addr_hit;

  // Mode code 3 folds back to off
  always_comb begin
    case (pwdata_i[1:0])
      2'd1:    wr_mode = obi_stall_pkg::STALL_FIXED;
      2'd2:    wr_mode = obi_stall_pkg::STALL_RANDOM;
      default: wr_mode = obi_stall_pkg::STALL_OFF;
    endcase
  end

  // Read mux, fields zero-extended
  always_comb begin
    case (paddr_i)
      `REG_CTRL:      rd_data = {30'd0, cfg_q.mode};
      `REG_GNT_STALL: rd_data = {28'd0, cfg_q.gnt_stall};
      `REG_MAX_STALL: rd_data = {28'd0, cfg_q.max_stall};
      `REG_RSP_STALL: rd_data = {29'd0, cfg_q.rsp_stall};
      default:        rd_data = 32'd0;
    endcase
  end

  // --------------------------------------------------
  // Register storage
  // --------------------------------------------------

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q    <= '0;
      prdata_o <= 32'd0;
    end else begin
      // Read data ready by the access phase
      if (setup) begin
        prdata_o <= pwrite_i ? 32'd0 : rd_data;
      end
      // Writes land at the access-phase edge
      if (access && pwrite_i) begin
        case (paddr_i)
          `REG_CTRL:      cfg_q.mode      <= wr_mode;
          `REG_GNT_STALL: cfg_q.gnt_stall <= pwdata_i[3:0];
          `REG_MAX_STALL: cfg_q.max_stall <= pwdata_i[3:0];
          `REG_RSP_STALL: cfg_q.rsp_stall <= pwdata_i[2:0];
          default:        cfg_q           <= cfg_q;
        endcase
      end
    end
  end

  assign cfg_o = cfg_q;

endmodule

// File: source/obi_gnt_stall.sv
// OBI grant staller with off, fixed and pseudo-random grant delay
`timescale 1ns/1ps
`include "obi_stall_settings.svh"

module obi_gnt_stall (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  obi_stall_pkg::stall_cfg_t cfg_i,
  output logic                      gnt_o
);

  // --------------------------------------------------
  // Pseudo-random source
  // --------------------------------------------------

  logic [15:0] lfsr_q;
  logic [15:0] lfsr_d;
  logic [4:0]  rnd_range;
  logic [15:0] rnd_mod;

  // Galois form, x^16 + x^14 + x^13 + x^11 + 1
  assign lfsr_d = {1'b0, lfsr_q[15:1]} ^ (lfsr_q[0] ? 16'hB400 : 16'h0000);

  // Free running, one step per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lfsr_q <= `LFSR_SEED;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  // Random delay in 0..max_stall
  assign rnd_range = {1'b0, cfg_i.max_stall} + 5'd1;
  assign rnd_mod   = lfsr_q % {11'd0, rnd_range};

  // --------------------------------------------------
  // Delay select and countdown
  // --------------------------------------------------

  logic       req_q;
  logic       gnt_q;
  logic       new_req;
  logic [3:0] delay;
  logic [3:0] cnt_q;

  always_comb begin
    case (cfg_i.mode)
      obi_stall_pkg::STALL_FIXED:  delay = cfg_i.gnt_stall;
      obi_stall_pkg::STALL_RANDOM: delay = rnd_mod[3:0];
      default:                     delay = 4'd0;
    endcase
  end

  // New transfer: req just rose, or follows a handshake
  assign new_req = req_i & (~req_q | gnt_q);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_q <= 1'b0;
      gnt_q <= 1'b0;
    end else begin
      req_q <= req_i;
      gnt_q <= gnt_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_o <= 1'b0;
      cnt_q <= 4'd0;
    end else if (!req_i) begin
      // Request withdrawn, start over
      gnt_o <= 1'b0;
      cnt_q <= 4'd0;
    end else if (gnt_o) begin
      // Handshake on this edge, drop grant
      gnt_o <= 1'b0;
    end else if (new_req) begin
      cnt_q <= delay;
    end else if (cnt_q == 4'd0) begin
      gnt_o <= 1'b1;
    end else begin
      cnt_q <= cnt_q - 4'd1;
    end
  end

endmodule

// File: source/obi_mem.sv
// Word-addressed RAM behind the OBI port, one access per handshake
`timescale 1ns/1ps
`include "obi_stall_settings.svh"

module obi_mem (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    xfer_i,
  input  obi_stall_pkg::obi_req_t req_i,
  output logic [`OBI_DATA_W-1:0]  rdata_o,
  output logic                    done_o,
  output logic                    done_we_o
);

  localparam int unsigned MEM_AW = $clog2(`OBI_MEM_WORDS);

  // --------------------------------------------------
  // Storage
  // --------------------------------------------------

  logic [`OBI_DATA_W-1:0] mem_q [`OBI_MEM_WORDS];
  logic [MEM_AW-1:0]      idx;

  // Byte address to word index, upper bits ignored
  assign idx = req_i.addr[MEM_AW+1:2];

  // Full-word write or read capture at the handshake
  always_ff @(posedge clk_i) begin
    if (xfer_i) begin
      if (req_i.we) begin
        mem_q[idx] <= req_i.wdata;
      end else begin
        rdata_o <= mem_q[idx];
      end
    end
  end

  // --------------------------------------------------
  // Completion strobe
  // --------------------------------------------------

  // One cycle, tagged with direction
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      done_o    <= 1'b0;
      done_we_o <= 1'b0;
    end else begin
      done_o    <= xfer_i;
      done_we_o <= xfer_i & req_i.we;
    end
  end

endmodule

// File: source/obi_rvalid_stall.sv
// Response staller, returns each OBI response a set number of cycles after handshake
`timescale 1ns/1ps
`include "obi_stall_settings.svh"

module obi_rvalid_stall (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    done_i,
  input  logic                    done_we_i,
  input  logic [`OBI_DATA_W-1:0]  rdata_i,
  input  logic [2:0]              rsp_stall_i,
  input  logic                    xfer_i,
  output obi_stall_pkg::obi_rsp_t rsp_o
);

  localparam int unsigned SLOTS = `RSP_DELAY_MAX + 1;

  // --------------------------------------------------
  // Per-transfer delay
  // --------------------------------------------------

  logic [2:0] delay_q;

  // Sampled at handshake, used one cycle later with done
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      delay_q <= 3'd0;
    end else if (xfer_i) begin
      delay_q <= rsp_stall_i;
    end
  end

  // --------------------------------------------------
  // Delay line
  // --------------------------------------------------

  obi_stall_pkg::obi_rsp_t slot_q [SLOTS];
  obi_stall_pkg::obi_rsp_t entry;

  // Writes return zero data
  assign entry.rvalid = 1'b1;
  assign entry.rdata  = done_we_i ? '0 : rdata_i;

  // Slot 0 is the output, entries move one slot per cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < SLOTS; i++) begin
        slot_q[i] <= '0;
      end
    end else begin
      for (int i = 0; i < SLOTS - 1; i++) begin
        slot_q[i] <= slot_q[i+1];
      end
      slot_q[SLOTS-1] <= '0;
      // Insert so it reaches slot 0 after delay_q more edges
      if (done_i) begin
        slot_q[delay_q] <= entry;
      end
    end
  end

  assign rsp_o = slot_q[0];

endmodule

// File: source/obi_stall_top.sv
// Stall-injecting OBI data memory with APB stall configuration
`timescale 1ns/1ps
`include "obi_stall_settings.svh"

module obi_stall_top (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // APB configuration port
  input  logic [11:0]             paddr_i,
  input  logic                    psel_i,
  input  logic                    penable_i,
  input  logic                    pwrite_i,
  input  logic [31:0]             pwdata_i,
  output logic [31:0]             prdata_o,
  output logic                    pready_o,
  output logic                    pslverr_o,
  // Core OBI data port
  input  obi_stall_pkg::obi_req_t obi_req_i,
  output logic                    gnt_o,
  output obi_stall_pkg::obi_rsp_t obi_rsp_o
);

  // --------------------------------------------------
  // Internal wiring
  // --------------------------------------------------

  obi_stall_pkg::stall_cfg_t cfg;
  logic                      xfer;
  logic [`OBI_DATA_W-1:0]    mem_rdata;
  logic                      mem_done;
  logic                      mem_done_we;

  // Handshake strobe
  assign xfer = obi_req_i.req & gnt_o;

  obi_stall_regs obi_stall_regs_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .paddr_i   (paddr_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .pwdata_i  (pwdata_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .pslverr_o (pslverr_o),
    .cfg_o     (cfg)
  );

  obi_gnt_stall obi_gnt_stall_i (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (obi_req_i.req),
    .cfg_i  (cfg),
    .gnt_o  (gnt_o)
  );

  obi_mem obi_mem_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .xfer_i    (xfer),
    .req_i     (obi_req_i),
    .rdata_o   (mem_rdata),
    .done_o    (mem_done),
    .done_we_o (mem_done_we)
  );

  // Response delay taken from the live config at handshake
  obi_rvalid_stall obi_rvalid_stall_i (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .done_i      (mem_done),
    .done_we_i   (mem_done_we),
    .rdata_i     (mem_rdata),
    .rsp_stall_i (cfg.rsp_stall),
    .xfer_i      (xfer),
    .rsp_o       (obi_rsp_o)
  );

endmodule

// File: test/obi_stall_checker.sv
// Protocol checker for the OBI stall memory, bound to the top level
`timescale 1ns/1ps

module obi_stall_checker (
  input logic clk_i,
  input logic rst_ni,
  input logic req_i,
  input logic gnt_i,
  input logic rvalid_i,
  input logic psel_i,
  input logic penable_i,
  input logic pslverr_i
);

  // Failure count, read by the testbench at the end of the run
  int unsigned fail_cnt = 0;

  // --------------------------------------------------
  // Reset behavior
  // --------------------------------------------------

  // Grant and response quiet while reset is held
  reset_quiet: assert property (@(posedge clk_i) !rst_ni |-> (!gnt_i && !rvalid_i))
    else begin
      fail_cnt++;
      $error("gnt_o or rvalid high while reset is held");
    end

  // --------------------------------------------------
  // OBI handshake rules
  // --------------------------------------------------

  // Grant is only raised for a pending request
  gnt_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(gnt_i) |-> $past(req_i))
    else begin
      fail_cnt++;
      $error("gnt_o rose without a request");
    end

  // One cycle per response
  rvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rvalid_i |=> !rvalid_i)
    else begin
      fail_cnt++;
      $error("rvalid stayed high for two cycles");
    end

  // APB error only in the access phase
  slverr_access: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pslverr_i |-> (psel_i && penable_i))
    else begin
      fail_cnt++;
      $error("pslverr_o high outside an access phase");
    end

endmodule

bind obi_stall_top obi_stall_checker obi_stall_checker_i (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (obi_req_i.req),
  .gnt_i     (gnt_o),
  .rvalid_i  (obi_rsp_o.rvalid),
  .psel_i    (psel_i),
  .penable_i (penable_i),
  .pslverr_i (pslverr_o)
);

// File: test/obi_stall_tb.sv
// Testbench for the stall-injecting OBI memory: APB setup, OBI traffic, response checks
`timescale 1ns/1ps
`include "obi_stall_settings.svh"

module obi_stall_tb;

  localparam int unsigned CLK_PERIOD = 4;
  // Worst case per transfer: 16 grant, 8 response and 4 APB cycles
  localparam int unsigned CYCLES_PER_XFER = 28;
  // Grant tests 20, random 20, data 32, dropped request 2
  localparam int unsigned PLANNED_XFERS = 74;

  logic                    clk_i;
  logic                    rst_ni;
  logic [11:0]             paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [31:0]             pwdata;
  logic [31:0]             prdata;
  logic                    pready;
  logic                    pslverr;
  logic                    gnt;
  obi_stall_pkg::obi_req_t obi_req;
  obi_stall_pkg::obi_rsp_t obi_rsp;

  int unsigned cyc = 0;
  int unsigned errors = 0;
  int unsigned checks = 0;
  int unsigned tests = 0;
  int unsigned test_err0 = 0;
  logic [2:0]  rsp_stall = 3'd0;
  logic [31:0] ref_mem [`OBI_MEM_WORDS];
  // Expected responses, in handshake order
  int unsigned due_q [$];
  logic [31:0] data_q [$];

  obi_stall_top obi_stall_top_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .paddr_i   (paddr),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pready_o  (pready),
    .pslverr_o (pslverr),
    .obi_req_i (obi_req),
    .gnt_o     (gnt),
    .obi_rsp_o (obi_rsp)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // Edge count, timestamps handshakes
  always @(posedge clk_i) cyc <= cyc + 1;

  // --------------------------------------------------
  // Checks and report
  // --------------------------------------------------

  task automatic compare_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
    checks++;
    assert (got === exp) else begin
      $display("mismatch at %0t: %s got 0x%08h, expected 0x%08h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic compare_range(input int unsigned got, input int unsigned lo,
                               input int unsigned hi, input string what);
    checks++;
    assert (got >= lo && got <= hi) else begin
      $display("mismatch at %0t: %s %0d outside %0d..%0d", $time, what, got, lo, hi);
      errors++;
    end
  endtask

  task automatic finish_test(input string name);
    tests++;
    $display("test %s finished with %0d errors", name, errors - test_err0);
    test_err0 = errors;
  endtask

  // Responses checked mid-cycle, away from the driving edge
  always @(negedge clk_i) begin
    if (rst_ni && obi_rsp.rvalid) begin
      if (due_q.size() == 0) begin
        $display("response at %0t with no transfer outstanding", $time);
        errors++;
      end else begin
        compare_value(cyc, due_q.pop_front(), "rvalid cycle");
        compare_value(obi_rsp.rdata, data_q.pop_front(), "rdata");
      end
    end else if (due_q.size() != 0 && cyc >= due_q[0]) begin
      $display("response missing at %0t, due in cycle %0d", $time, due_q[0]);
      errors++;
      void'(due_q.pop_front());
      void'(data_q.pop_front());
    end
  end

  // --------------------------------------------------
  // Bus tasks
  // --------------------------------------------------

  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, input logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(posedge clk_i);
    #1;
    penable = 1'b1;
    // Let the access-phase decode settle
    #1;
    compare_value(pready, 1, "pready_o");
    compare_value(pslverr, err, "pslverr_o on write");
    @(posedge clk_i);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp, input logic err);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(posedge clk_i);
    #1;
    penable = 1'b1;
    #1;
    compare_value(pslverr, err, "pslverr_o on read");
    compare_value(prdata, exp, "prdata_o");
    @(posedge clk_i);
    #1;
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  // One transfer; grant latency counted from the first sampling edge
  task automatic obi_access(input logic we, input logic [7:0] idx, input logic [31:0] wdata,
                            input int unsigned lo, input int unsigned hi);
    int unsigned n;
    n = 0;
    obi_req.req   = 1'b1;
    obi_req.we    = we;
    // Upper address bits are ignored by the RAM
    obi_req.addr  = {22'($urandom()), idx, 2'b00};
    obi_req.wdata = wdata;
    do begin
      @(posedge clk_i);
      #1;
      n++;
    end while (!gnt && n < 40);
    if (!gnt) begin
      $display("no grant within 40 cycles at %0t", $time);
      errors++;
    end else begin
      compare_range(n - 1, lo, hi, "grant latency");
      // Handshake edge
      @(posedge clk_i);
      #1;
      due_q.push_back(cyc + rsp_stall + 1);
      data_q.push_back(we ? 32'd0 : ref_mem[idx]);
      if (we) begin
        ref_mem[idx] = wdata;
      end
    end
  endtask

  task automatic obi_release();
    obi_req.req = 1'b0;
    @(posedge clk_i);
    #1;
  endtask

  task automatic wait_drained();
    while (due_q.size() != 0) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  // Two single requests, then three held back to back
  task automatic grant_round(input int unsigned lo, input int unsigned hi);
    repeat (2) begin
      obi_access(1'b1, 8'($urandom()), $urandom(), lo, hi);
      obi_release();
    end
    repeat (3) obi_access(1'b1, 8'($urandom()), $urandom(), lo, hi);
    obi_release();
  endtask

  // --------------------------------------------------
  // Watchdog
  // --------------------------------------------------

  initial begin
    #(PLANNED_XFERS * CYCLES_PER_XFER * CLK_PERIOD * 2);
    $display("timeout, the run did not finish within the expected time");
    $display("TEST FAIL");
    $finish;
  end

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    int unsigned d_list [3];
    int unsigned m_list [2];
    logic [7:0]  idx_list [8];
    int unsigned n_rnd;
    d_list = '{0, 3, 15};
    m_list = '{0, 5};
    void'($urandom(61));
    rst_ni  = 1'b1;
    paddr   = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    pwdata  = '0;
    obi_req = '0;
    #1;
    rst_ni = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;

    // Quiet outputs and cleared registers
    compare_value(gnt, 0, "gnt_o after reset");
    compare_value(obi_rsp.rvalid, 0, "rvalid after reset");
    compare_value(pslverr, 0, "pslverr_o after reset");
    apb_read(`REG_CTRL, 0, 0);
    apb_read(`REG_GNT_STALL, 0, 0);
    apb_read(`REG_MAX_STALL, 0, 0);
    apb_read(`REG_RSP_STALL, 0, 0);
    finish_test("reset");

    // Read back, unused offset, illegal mode
    apb_write(`REG_CTRL, obi_stall_pkg::STALL_FIXED, 0);
    apb_write(`REG_GNT_STALL, 32'hFFFF_FFFA, 0);
    apb_write(`REG_MAX_STALL, 32'h5, 0);
    apb_write(`REG_RSP_STALL, 32'h6, 0);
    apb_read(`REG_CTRL, 1, 0);
    apb_read(`REG_GNT_STALL, 32'hA, 0);
    apb_read(`REG_MAX_STALL, 32'h5, 0);
    apb_read(`REG_RSP_STALL, 32'h6, 0);
    apb_write(12'h010, 32'hF, 1);
    apb_read(12'h010, 0, 1);
    apb_read(`REG_CTRL, 1, 0);
    apb_read(`REG_GNT_STALL, 32'hA, 0);
    apb_read(`REG_MAX_STALL, 32'h5, 0);
    apb_read(`REG_RSP_STALL, 32'h6, 0);
    apb_write(`REG_CTRL, 32'h3, 0);
    apb_read(`REG_CTRL, obi_stall_pkg::STALL_OFF, 0);
    apb_write(`REG_RSP_STALL, 0, 0);
    rsp_stall = 3'd0;
    finish_test("registers");

    // Off mode ignores gnt_stall
    apb_write(`REG_GNT_STALL, 3, 0);
    grant_round(1, 1);
    apb_write(`REG_CTRL, obi_stall_pkg::STALL_FIXED, 0);
    for (int i = 0; i < 3; i++) begin
      apb_write(`REG_GNT_STALL, d_list[i], 0);
      grant_round(d_list[i] + 1, d_list[i] + 1);
    end
    finish_test("fixed_grant");

    apb_write(`REG_CTRL, obi_stall_pkg::STALL_RANDOM, 0);
    for (int i = 0; i < 2; i++) begin
      apb_write(`REG_MAX_STALL, m_list[i], 0);
      n_rnd = 6 + $urandom() % 5;
      repeat (n_rnd) obi_access(1'b1, 8'($urandom()), $urandom(), 1, m_list[i] + 1);
      obi_release();
    end
    finish_test("random_grant");

    // Writes then reads, short and long response delay
    apb_write(`REG_CTRL, obi_stall_pkg::STALL_OFF, 0);
    for (int r = 0; r < 8; r += 7) begin
      wait_drained();
      apb_write(`REG_RSP_STALL, r, 0);
      rsp_stall = 3'(r);
      for (int i = 0; i < 8; i++) begin
        idx_list[i] = 8'($urandom());
        obi_access(1'b1, idx_list[i], $urandom(), 1, 1);
      end
      obi_release();
      for (int i = 0; i < 8; i++) begin
        obi_access(1'b0, idx_list[i], 32'd0, 1, 1);
      end
      obi_release();
    end
    wait_drained();
    finish_test("data");

    // Request withdrawn one edge before its grant is due
    apb_write(`REG_GNT_STALL, 5, 0);
    apb_write(`REG_CTRL, obi_stall_pkg::STALL_FIXED, 0);
    obi_req.req = 1'b1;
    obi_req.we  = 1'b1;
    repeat (5) begin
      @(posedge clk_i);
      #1;
      compare_value(gnt, 0, "gnt_o before drop");
    end
    obi_req.req = 1'b0;
    repeat (2) begin
      @(posedge clk_i);
      #1;
      compare_value(gnt, 0, "gnt_o after drop");
    end
    obi_access(1'b1, 8'($urandom()), $urandom(), 6, 6);
    obi_release();
    wait_drained();
    finish_test("dropped_req");

    $display("%0d tests, %0d checks, %0d errors, %0d assertion failures", tests, checks,
             errors, obi_stall_top_i.obi_stall_checker_i.fail_cnt);
    if (errors == 0 && obi_stall_top_i.obi_stall_checker_i.fail_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// File: tb.f
+incdir+source
source/obi_stall_pkg.sv
source/obi_stall_regs.sv
source/obi_gnt_stall.sv
source/obi_mem.sv
source/obi_rvalid_stall.sv
source/obi_stall_top.sv
test/obi_stall_checker.sv
test/obi_stall_tb.sv
